// File: Bender.yml
package:
  name: userio_osd

sources:
  - rtl/osd_pkg.sv
  - rtl/osd_io_port.sv
  - rtl/osd_cmd_decoder.sv
  - rtl/osd_char_buffer.sv
  - rtl/osd_video_gen.sv
  - rtl/userio_osd.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_userio_osd.sv

// File: list.f
+incdir+tests
rtl/osd_pkg.sv
rtl/osd_io_port.sv
rtl/osd_cmd_decoder.sv
rtl/osd_char_buffer.sv
rtl/osd_video_gen.sv
rtl/userio_osd.sv
tests/tb_userio_osd.sv

// File: rtl/osd_char_buffer.sv
// 2048x8 character RAM, 8 lines of 256 bytes; read data valid one clock after rd_addr
`timescale 1ns/1ps

module osd_char_buffer (
  input  logic                clk,
  input  osd_pkg::buf_wr_t    buf_wr,
  input  osd_pkg::buf_addr_t  rd_addr,
  output osd_pkg::osd_byte_t  rd_byte
);
  import osd_pkg::*;

  // single block ram, one write and one read port
  osd_byte_t mem [0:2047];
  buf_addr_t wr_addr;

  // ----------------------------------------
  // write side
  // ----------------------------------------
  // load points at the start of a line, each write steps by one
  always_ff @(posedge clk) begin
    if (buf_wr.load) begin
      wr_addr <= {buf_wr.line, 8'h00};
    end else if (buf_wr.we) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (buf_wr.we) begin
      mem[wr_addr] <= buf_wr.data;
    end
  end

  // ----------------------------------------
  // read side
  // ----------------------------------------
  // registered output keeps it inside the ram primitive
  always_ff @(posedge clk) begin
    rd_byte <= mem[rd_addr];
  end

endmodule

// File: rtl/osd_cmd_decoder.sv
// command decoder; chipset, ide, cpu[1:0] and memory[5:0] only take effect while reset is high
`timescale 1ns/1ps

module osd_cmd_decoder (
  input  logic               clk,
  input  logic               reset,
  input  logic               rx,
  input  logic               is_cmd,
  input  osd_pkg::io_word_t  rx_data,
  input  osd_pkg::osd_byte_t osd_ctrl,
  output osd_pkg::osd_byte_t rd_data,
  output osd_pkg::sys_cfg_t  sys_cfg,
  output osd_pkg::sys_ctrl_t sys_ctrl,
  output osd_pkg::buf_wr_t   buf_wr,
  output osd_pkg::highlight_t highlight
);
  import osd_pkg::*;

  cmd_code_t  cmd_q;
  // data word counter, saturates at 4
  logic [2:0] cnt_q;
  logic       wr_en_q;
  logic       data_rx;
  logic       first_data;
  logic       buf_sel;
  logic       buf_load;
  logic [1:0] ver_idx;

  // staged values, copied to the outputs during reset
  logic [4:0] chipset_stg = '0;
  logic [3:0] cpu_stg     = '0;
  logic [6:0] memory_stg  = MEMORY_CFG_DEFAULT;
  logic [2:0] ide_stg     = '0;

  sys_cfg_t  cfg_q  = '{memory: MEMORY_CFG_DEFAULT, default: '0};
  sys_ctrl_t ctrl_q = '{cpurst: 1'b1, cpuhlt: 1'b1, default: 1'b0};

  assign data_rx    = rx && !is_cmd;
  assign first_data = data_rx && (cnt_q == 3'd0);
  assign buf_sel    = (cmd_q == CMD_OSD_BUFFER);
  assign buf_load   = data_rx && buf_sel && (cnt_q == 3'd3);

  // ----------------------------------------
  // command latch and word counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_q   <= '0;
      cnt_q   <= '0;
      wr_en_q <= 1'b0;
    end else if (rx && is_cmd) begin
      cmd_q   <= rx_data[7:2];
      cnt_q   <= '0;
      wr_en_q <= 1'b0;
    end else if (rx) begin
      if (cnt_q != 3'd4) begin
        cnt_q <= cnt_q + 3'd1;
      end
      // words after the line select are characters
      if (buf_load) begin
        wr_en_q <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // configuration registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (first_data) begin
      case (cmd_q)
        CMD_RESET_CTRL:   {ctrl_q.cpuhlt, ctrl_q.cpurst, ctrl_q.usrrst} <= rx_data[2:0];
        CMD_OSD_CTRL:     {ctrl_q.key_disable, ctrl_q.osd_enable} <= rx_data[1:0];
        CMD_CHIP_CFG:     chipset_stg <= rx_data[4:0];
        CMD_CPU_CFG:      cpu_stg <= rx_data[3:0];
        CMD_MEMORY_CFG:   memory_stg <= rx_data[6:0];
        CMD_VIDEO_CFG: begin
          {cfg_q.blver, cfg_q.ar, cfg_q.dither,
           cfg_q.hr_filter, cfg_q.lr_filter, cfg_q.scanline} <= rx_data[11:0];
        end
        CMD_FLOPPY_CFG:   cfg_q.floppy <= rx_data[3:0];
        CMD_HARDDISK_CFG: ide_stg <= rx_data[2:0];
        CMD_JOYSTICK_CFG: begin
          // bits 11..9 enable each field separately
          if (rx_data[11]) begin
            cfg_q.joy_swap <= rx_data[3];
          end
          if (rx_data[10]) begin
            cfg_q.cd32pad <= rx_data[2];
          end
          if (rx_data[9]) begin
            cfg_q.autofire <= rx_data[1:0];
          end
        end
        default: ;
      endcase
    end
    // core can't change chipset, disk, cpu type or memory map while running
    if (reset) begin
      cfg_q.chipset     <= chipset_stg;
      cfg_q.ide         <= ide_stg;
      cfg_q.cpu[1:0]    <= cpu_stg[1:0];
      cfg_q.memory[5:0] <= memory_stg[5:0];
    end
    // cache, kickstart and hrtmon bits are safe at any time
    cfg_q.cpu[3:2]  <= cpu_stg[3:2];
    cfg_q.memory[6] <= memory_stg[6];
  end

  // highlight is dropped whenever the osd is off
  always_ff @(posedge clk) begin
    if (!ctrl_q.osd_enable) begin
      highlight <= HIGHLIGHT_NONE;
    end else if (buf_load && rx_data[4]) begin
      highlight <= rx_data[3:0];
    end
  end

  assign buf_wr = '{load: buf_load, line: rx_data[2:0], we: data_rx && wr_en_q,
                    data: rx_data[7:0]};

  // readback, counter 4 repeats the last version byte
  assign ver_idx = (cnt_q > 3'd3) ? 2'd3 : cnt_q[1:0];
  assign rd_data = (cmd_q == CMD_VERSION) ? VERSION_BYTES[ver_idx] : osd_ctrl;

  assign sys_cfg  = cfg_q;
  assign sys_ctrl = ctrl_q;

endmodule

// File: rtl/osd_io_port.sv
// host byte port; host must not strobe while io_wait is high, io_ena low restarts with a command
`timescale 1ns/1ps

module osd_io_port #(
  parameter int WAIT_CYCLES = 4
) (
  input  logic               clk,
  input  logic               io_ena,
  input  logic               io_strobe,
  input  osd_pkg::io_word_t  io_din,
  input  osd_pkg::osd_byte_t rd_data,
  output logic               io_wait,
  output osd_pkg::io_word_t  io_dout,
  output logic               rx,
  output logic               is_cmd,
  output osd_pkg::io_word_t  rx_data
);
  import osd_pkg::*;

  localparam int TW = $clog2(WAIT_CYCLES + 1);

  // first word after enable rises is a command
  logic          first_q;
  // word latched, rx pulse due next cycle
  logic          pend_q;
  logic [TW-1:0] timeout_q;
  io_word_t      din_q;
  osd_byte_t     dout_q;

  always_ff @(posedge clk) begin
    if (!io_ena) begin
      // enable low acts as the port reset
      first_q   <= 1'b1;
      pend_q    <= 1'b0;
      io_wait   <= 1'b0;
      rx        <= 1'b0;
      is_cmd    <= 1'b0;
      dout_q    <= '0;
      timeout_q <= '0;
    end else if (io_strobe) begin
      is_cmd    <= first_q;
      first_q   <= 1'b0;
      pend_q    <= 1'b1;
      rx        <= 1'b0;
      io_wait   <= 1'b1;
      timeout_q <= TW'(WAIT_CYCLES);
      din_q     <= io_din;
    end else begin
      rx     <= pend_q;
      pend_q <= 1'b0;
      if (pend_q) begin
        // hand word to decoder, grab readback for this counter value
        rx_data <= din_q;
        dout_q  <= rd_data;
      end else if (timeout_q != '0) begin
        timeout_q <= timeout_q - 1'b1;
      end else begin
        io_wait <= 1'b0;
      end
    end
  end

  // readback is a byte, upper half always zero
  assign io_dout = io_ena ? {8'h00, dout_q} : '0;

endmodule

// File: rtl/osd_pkg.sv
// shared types and constants; command codes are the upper six bits of a command byte
package osd_pkg;

  // ----------------------------------------
  // widths with a meaning
  // ----------------------------------------
  typedef logic [15:0] io_word_t;
  typedef logic [7:0]  osd_byte_t;
  typedef logic [10:0] buf_addr_t;
  // top bit set means no line is highlighted
  typedef logic [3:0]  highlight_t;
  typedef logic [5:0]  cmd_code_t;

  // ----------------------------------------
  // command codes
  // ----------------------------------------
  // write regs, data word 0 carries the value
  localparam cmd_code_t CMD_RESET_CTRL   = 6'b0_000_10;
  localparam cmd_code_t CMD_OSD_CTRL     = 6'b0_010_10;
  localparam cmd_code_t CMD_CHIP_CFG     = 6'b0_000_01;
  localparam cmd_code_t CMD_CPU_CFG      = 6'b0_001_01;
  localparam cmd_code_t CMD_MEMORY_CFG   = 6'b0_010_01;
  localparam cmd_code_t CMD_VIDEO_CFG    = 6'b0_011_01;
  localparam cmd_code_t CMD_FLOPPY_CFG   = 6'b0_100_01;
  localparam cmd_code_t CMD_HARDDISK_CFG = 6'b0_101_01;
  localparam cmd_code_t CMD_JOYSTICK_CFG = 6'b0_110_01;
  // word 3 selects the line, later words are characters
  localparam cmd_code_t CMD_OSD_BUFFER   = 6'b0_000_11;
  localparam cmd_code_t CMD_VERSION      = 6'b1_000_10;

  // ----------------------------------------
  // defaults and fixed data
  // ----------------------------------------
  localparam highlight_t HIGHLIGHT_NONE = 4'b1000;
  // beta flag, major, minor, minion
  localparam osd_byte_t [0:3] VERSION_BYTES = '{8'h00, 8'h01, 8'h04, 8'h02};
  // hrtmon off, no fast, 512k slow, 512k chip
  localparam logic [6:0] MEMORY_CFG_DEFAULT = 7'b0_00_01_01;

  // configuration outputs towards the core
  typedef struct packed {
    logic [4:0] chipset;
    logic [3:0] cpu;
    logic [6:0] memory;
    logic [2:0] ide;
    logic [3:0] floppy;
    logic [1:0] scanline;
    logic [1:0] lr_filter;
    logic [1:0] hr_filter;
    logic [1:0] dither;
    logic [1:0] ar;
    logic [1:0] blver;
    logic [1:0] autofire;
    logic       cd32pad;
    logic       joy_swap;
  } sys_cfg_t;

  // reset and osd control bits
  typedef struct packed {
    logic usrrst;
    logic cpurst;
    logic cpuhlt;
    logic osd_enable;
    logic key_disable;
  } sys_ctrl_t;

  // character buffer write request, one word per rx pulse
  typedef struct packed {
    logic      load;
    logic [2:0] line;
    logic      we;
    osd_byte_t data;
  } buf_wr_t;

endpackage

// File: rtl/osd_video_gen.sv
// osd beam logic at half pixel clock; sol and sof are single-cycle strobes from the video core
`timescale 1ns/1ps

module osd_video_gen #(
  parameter int OSD_LEFT  = 448,
  parameter int OSD_TOP   = 128,
  parameter int OSD_LINES = 64
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                sol,
  input  logic                sof,
  input  logic                osd_enable,
  input  osd_pkg::highlight_t highlight,
  input  osd_pkg::osd_byte_t  rd_byte,
  output osd_pkg::buf_addr_t  rd_addr,
  output logic                osd_blank,
  output logic                osd_pixel
);

  // pixel clock counter, one osd column every two counts
  logic [10:0] hcnt_q;
  logic [8:0]  vcnt_q;
  // enable only changes on a frame boundary
  logic        osd_on_q;
  logic [9:0]  col;
  logic [8:0]  vline;
  logic [7:0]  hpos;
  logic        hframe;
  logic        vframe;
  logic        row_hit;
  // pixel stage, aligned with ram output
  logic        blank_q;
  logic [2:0]  bit_q;
  logic        inv_q;

  // ----------------------------------------
  // beam counters
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset || sol) begin
      hcnt_q <= '0;
    end else begin
      hcnt_q <= hcnt_q + 11'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || sof) begin
      vcnt_q <= '0;
    end else if (sol) begin
      vcnt_q <= vcnt_q + 9'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      osd_on_q <= 1'b0;
    end else if (sof) begin
      osd_on_q <= osd_enable;
    end
  end

  // ----------------------------------------
  // window and buffer address
  // ----------------------------------------
  assign col    = hcnt_q[10:1];
  assign hframe = (int'(col) >= OSD_LEFT) && (int'(col) < OSD_LEFT + 256);
  assign vframe = (int'(vcnt_q) >= OSD_TOP) && (int'(vcnt_q) < OSD_TOP + OSD_LINES);

  // position inside the window
  assign vline = vcnt_q - 9'(OSD_TOP);
  assign hpos  = col[7:0] - 8'(OSD_LEFT);

  // text row in the upper bits, 8 scan lines per row
  assign rd_addr = {vline[5:3], hpos};

  assign row_hit   = !highlight[3] && (vline[5:3] == highlight[2:0]);
  assign osd_blank = hframe && vframe && osd_on_q;

  // ----------------------------------------
  // pixel output
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      blank_q <= 1'b0;
    end else begin
      blank_q <= osd_blank;
    end
  end

  always_ff @(posedge clk) begin
    bit_q <= vline[2:0];
    inv_q <= row_hit;
  end

  // each byte is a vertical strip of 8 pixels, bit 0 on top
  assign osd_pixel = blank_q && (rd_byte[bit_q] ^ inv_q);

endmodule

// File: rtl/userio_osd.sv
// osd controller top; no system memory path, osd always runs at half the pixel clock
`timescale 1ns/1ps

module userio_osd #(
  parameter int WAIT_CYCLES = 4,
  parameter int OSD_LEFT    = 448,
  parameter int OSD_TOP     = 128,
  parameter int OSD_LINES   = 64
) (
  input  logic               clk,
  input  logic               reset,
  // host byte port
  input  logic               io_ena,
  input  logic               io_strobe,
  input  osd_pkg::io_word_t  io_din,
  output logic               io_wait,
  output osd_pkg::io_word_t  io_dout,
  // video timing and overlay
  input  logic               sol,
  input  logic               sof,
  output logic               osd_blank,
  output logic               osd_pixel,
  // keyboard control code
  input  osd_pkg::osd_byte_t osd_ctrl,
  output osd_pkg::sys_cfg_t  sys_cfg,
  output osd_pkg::sys_ctrl_t sys_ctrl
);
  import osd_pkg::*;

  // ----------------------------------------
  // port to decoder
  // ----------------------------------------
  logic       rx;
  logic       is_cmd;
  io_word_t   rx_data;
  osd_byte_t  rd_data;

  // decoder to buffer and video
  buf_wr_t    buf_wr;
  highlight_t highlight;
  buf_addr_t  rd_addr;
  osd_byte_t  rd_byte;

  osd_io_port #(
    .WAIT_CYCLES (WAIT_CYCLES)
  ) io_port_inst (
    .clk       (clk),
    .io_ena    (io_ena),
    .io_strobe (io_strobe),
    .io_din    (io_din),
    .rd_data   (rd_data),
    .io_wait   (io_wait),
    .io_dout   (io_dout),
    .rx        (rx),
    .is_cmd    (is_cmd),
    .rx_data   (rx_data)
  );

  osd_cmd_decoder cmd_decoder_inst (
    .clk       (clk),
    .reset     (reset),
    .rx        (rx),
    .is_cmd    (is_cmd),
    .rx_data   (rx_data),
    .osd_ctrl  (osd_ctrl),
    .rd_data   (rd_data),
    .sys_cfg   (sys_cfg),
    .sys_ctrl  (sys_ctrl),
    .buf_wr    (buf_wr),
    .highlight (highlight)
  );

  osd_char_buffer char_buffer_inst (
    .clk     (clk),
    .buf_wr  (buf_wr),
    .rd_addr (rd_addr),
    .rd_byte (rd_byte)
  );

  osd_video_gen #(
    .OSD_LEFT  (OSD_LEFT),
    .OSD_TOP   (OSD_TOP),
    .OSD_LINES (OSD_LINES)
  ) video_gen_inst (
    .clk        (clk),
    .reset      (reset),
    .sol        (sol),
    .sof        (sof),
    .osd_enable (sys_ctrl.osd_enable),
    .highlight  (highlight),
    .rd_byte    (rd_byte),
    .rd_addr    (rd_addr),
    .osd_blank  (osd_blank),
    .osd_pixel  (osd_pixel)
  );

endmodule

// File: tests/tb_osd_tasks.svh
// host port and video strobe tasks; included inside tb_userio_osd and uses its signals and counters

// ----------------------------------------
// host port
// ----------------------------------------
// one word per call, strobe then wait for io_wait to drop
task automatic port_write(input io_word_t word, output osd_byte_t rb);
  int n;
  n = 0;
  @(posedge clk);
  #1;
  io_din    = word;
  io_strobe = 1'b1;
  @(posedge clk);
  #1;
  io_strobe = 1'b0;
  assert (io_wait) else begin
    $display("%s: io_wait did not rise after a strobe", cur_test);
    test_errs++;
  end
  // bounded wait, the port must let go within WAIT_CYCLES+3
  while (io_wait && n < WAIT_CYCLES + 3) begin
    @(posedge clk);
    #1;
    n++;
  end
  wait_seen = n;
  assert (!io_wait) else begin
    $display("%s: timeout, io_wait still high after %0d cycles", cur_test, n);
    test_errs++;
  end
  // readback byte was captured one cycle after the strobe
  rb = io_dout[7:0];
endtask

// enable low for a cycle so the next word is a command
task automatic start_cmd(input cmd_code_t code);
  osd_byte_t cmd_rb;
  @(posedge clk);
  #1;
  io_ena = 1'b0;
  @(posedge clk);
  #1;
  io_ena = 1'b1;
  port_write({8'h00, code, 2'b00}, cmd_rb);
endtask

task automatic end_cmd();
  @(posedge clk);
  #1;
  io_ena = 1'b0;
endtask

// command plus a single data word
task automatic write_config(input cmd_code_t code, input io_word_t word);
  osd_byte_t cfg_rb;
  start_cmd(code);
  port_write(word, cfg_rb);
  end_cmd();
endtask

// ----------------------------------------
// video strobes
// ----------------------------------------
// single-cycle sof, ends 1 ns after the edge that took it
task automatic frame_start();
  @(posedge clk);
  #1;
  sof = 1'b1;
  @(posedge clk);
  #1;
  sof = 1'b0;
endtask

// single-cycle sol, hcnt is 0 when this returns
task automatic line_start();
  @(posedge clk);
  #1;
  sol = 1'b1;
  @(posedge clk);
  #1;
  sol = 1'b0;
endtask

// File: tests/tb_userio_osd.sv
// testbench for userio_osd; small OSD window, buffer contents known only for text row 2
`timescale 1ns/1ps

module tb_userio_osd;
  import osd_pkg::*;

  localparam int WAIT_CYCLES = 4;
  localparam int OSD_LEFT    = 24;
  localparam int OSD_TOP     = 6;
  localparam int OSD_LINES   = 64;
  // a line runs a little past the right edge of the window
  localparam int LINE_CLKS   = 2 * (OSD_LEFT + 256) + 8;
  localparam int HL_ROW      = 2;

  logic      clk;
  logic      reset;
  logic      io_ena;
  logic      io_strobe;
  io_word_t  io_din;
  logic      io_wait;
  io_word_t  io_dout;
  logic      sol;
  logic      sof;
  logic      osd_blank;
  logic      osd_pixel;
  osd_byte_t osd_ctrl;
  sys_cfg_t  sys_cfg;
  sys_ctrl_t sys_ctrl;

  // bookkeeping
  string     cur_test;
  int        test_errs;
  int        total_errs;
  int        tests_run;
  int        tests_failed;
  int        wait_seen;
  int        seed;
  // bytes written to text row 2
  osd_byte_t row_bytes [0:255];

  userio_osd #(
    .WAIT_CYCLES (WAIT_CYCLES),
    .OSD_LEFT    (OSD_LEFT),
    .OSD_TOP     (OSD_TOP),
    .OSD_LINES   (OSD_LINES)
  ) userio_osd_inst (
    .clk       (clk),
    .reset     (reset),
    .io_ena    (io_ena),
    .io_strobe (io_strobe),
    .io_din    (io_din),
    .io_wait   (io_wait),
    .io_dout   (io_dout),
    .sol       (sol),
    .sof       (sof),
    .osd_blank (osd_blank),
    .osd_pixel (osd_pixel),
    .osd_ctrl  (osd_ctrl),
    .sys_cfg   (sys_cfg),
    .sys_ctrl  (sys_ctrl)
  );

  `include "tb_osd_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // check helpers
  // ----------------------------------------
  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Fail %s %s expected %0h actual %0h", cur_test, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s ok", cur_test);
    end else begin
      $display("test %s failed with %0d errors", cur_test, test_errs);
      tests_failed++;
    end
  endtask

  task automatic pulse_reset(input int cycles);
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  // model pixel: bit 0 of a byte is the top scan line of its text row
  function automatic logic expected_pixel(input int col, input int n);
    osd_byte_t b;
    b = row_bytes[col - OSD_LEFT];
    return b[(n - OSD_TOP) % 8] ^ (((n - OSD_TOP) / 8) == HL_ROW);
  endfunction

  // one video line, blank checked every clock, pixel on the second clock of a column
  task automatic scan_line(input int n, input logic on);
    int   t;
    int   col;
    logic in_win;
    line_start();
    for (t = 0; t < LINE_CLKS; t++) begin
      if (t > 0) begin
        @(posedge clk);
        #1;
      end
      col    = t / 2;
      in_win = on && col >= OSD_LEFT && col < OSD_LEFT + 256 &&
               n >= OSD_TOP && n < OSD_TOP + OSD_LINES;
      compare_value("osd_blank", in_win, osd_blank);
      if (t % 2 == 1) begin
        if (!in_win) begin
          compare_value("osd_pixel outside window", 1'b0, osd_pixel);
        end else if ((n - OSD_TOP) / 8 == HL_ROW) begin
          compare_value("osd_pixel", expected_pixel(col, n), osd_pixel);
        end
      end
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    osd_byte_t  rb;
    io_word_t   joy_words [0:2];
    logic       exp_swap;
    logic       exp_cd32;
    logic [1:0] exp_af;
    int         i;
    int         n;

    reset        = 1'b1;
    io_ena       = 1'b0;
    io_strobe    = 1'b0;
    io_din       = '0;
    sol          = 1'b0;
    sof          = 1'b0;
    osd_ctrl     = 8'hc3;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    seed         = 18053;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    begin_test("wait_protocol");
    compare_value("io_wait after reset", 1'b0, io_wait);
    compare_value("osd_blank after reset", 1'b0, osd_blank);
    start_cmd(CMD_OSD_BUFFER);
    // wait set after the strobe, rx one later, release WAIT_CYCLES+1 after rx
    compare_value("wait length", WAIT_CYCLES + 2, wait_seen);
    port_write(16'h0000, rb);
    compare_value("wait length", WAIT_CYCLES + 2, wait_seen);
    compare_value("readback", osd_ctrl, rb);
    compare_value("io_dout upper byte", 8'h00, io_dout[15:8]);
    end_cmd();
    // readback byte is still held, io_dout drops with io_ena alone
    #1;
    compare_value("io_dout at io_ena fall", 16'h0000, io_dout);
    repeat (3) begin
      @(posedge clk);
      #1;
      compare_value("io_dout with io_ena low", 16'h0000, io_dout);
      compare_value("io_wait with io_ena low", 1'b0, io_wait);
    end
    // drop io_ena in the middle of a wait
    @(posedge clk);
    #1;
    io_ena = 1'b1;
    @(posedge clk);
    #1;
    io_din    = 16'h0000;
    io_strobe = 1'b1;
    @(posedge clk);
    #1;
    io_strobe = 1'b0;
    io_ena    = 1'b0;
    compare_value("io_wait after strobe", 1'b1, io_wait);
    @(posedge clk);
    #1;
    compare_value("io_wait cut by io_ena low", 1'b0, io_wait);
    finish_test();

    begin_test("version_readback");
    start_cmd(CMD_VERSION);
    for (i = 0; i < 4; i++) begin
      port_write(16'h0000, rb);
      compare_value("version byte", VERSION_BYTES[i], rb);
    end
    end_cmd();
    // any other command reads the keyboard code
    start_cmd(CMD_OSD_BUFFER);
    for (i = 0; i < 2; i++) begin
      port_write(16'h0000, rb);
      compare_value("osd_ctrl readback", osd_ctrl, rb);
    end
    end_cmd();
    finish_test();

    begin_test("direct_config");
    write_config(CMD_VIDEO_CFG, 16'h0b6d);
    compare_value("scanline", 2'b01, sys_cfg.scanline);
    compare_value("lr_filter", 2'b11, sys_cfg.lr_filter);
    compare_value("hr_filter", 2'b10, sys_cfg.hr_filter);
    compare_value("dither", 2'b01, sys_cfg.dither);
    compare_value("ar", 2'b11, sys_cfg.ar);
    compare_value("blver", 2'b10, sys_cfg.blver);
    write_config(CMD_FLOPPY_CFG, 16'h0009);
    compare_value("floppy", 4'h9, sys_cfg.floppy);
    write_config(CMD_OSD_CTRL, 16'h0003);
    compare_value("osd_enable", 1'b1, sys_ctrl.osd_enable);
    compare_value("key_disable", 1'b1, sys_ctrl.key_disable);
    // each word carries data for all fields, masks pick which ones land
    joy_words[0] = 16'h080f;
    joy_words[1] = 16'h020a;
    joy_words[2] = 16'h0405;
    exp_swap = 1'b0;
    exp_cd32 = 1'b0;
    exp_af   = 2'b00;
    for (i = 0; i < 3; i++) begin
      write_config(CMD_JOYSTICK_CFG, joy_words[i]);
      if (joy_words[i][11]) begin
        exp_swap = joy_words[i][3];
      end
      if (joy_words[i][10]) begin
        exp_cd32 = joy_words[i][2];
      end
      if (joy_words[i][9]) begin
        exp_af = joy_words[i][1:0];
      end
      compare_value("joy_swap", exp_swap, sys_cfg.joy_swap);
      compare_value("cd32pad", exp_cd32, sys_cfg.cd32pad);
      compare_value("autofire", exp_af, sys_cfg.autofire);
    end
    finish_test();

    begin_test("reset_gated_config");
    compare_value("memory default", 7'b0_00_01_01, sys_cfg.memory);
    compare_value("cpurst default", 1'b1, sys_ctrl.cpurst);
    compare_value("cpuhlt default", 1'b1, sys_ctrl.cpuhlt);
    write_config(CMD_CHIP_CFG, 16'h0015);
    write_config(CMD_HARDDISK_CFG, 16'h0005);
    write_config(CMD_CPU_CFG, 16'h000e);
    write_config(CMD_MEMORY_CFG, 16'h005a);
    // only cpu[3:2] and memory[6] move before the reset
    compare_value("chipset before reset", 5'h00, sys_cfg.chipset);
    compare_value("ide before reset", 3'h0, sys_cfg.ide);
    compare_value("cpu before reset", 4'b1100, sys_cfg.cpu);
    compare_value("memory before reset", 7'b1_00_01_01, sys_cfg.memory);
    pulse_reset(2);
    compare_value("chipset after reset", 5'h15, sys_cfg.chipset);
    compare_value("ide after reset", 3'h5, sys_cfg.ide);
    compare_value("cpu after reset", 4'he, sys_cfg.cpu);
    compare_value("memory after reset", 7'h5a, sys_cfg.memory);
    compare_value("io_wait after reset", 1'b0, io_wait);
    compare_value("osd_blank after reset", 1'b0, osd_blank);
    // reset control bits 2..0 are cpuhlt, cpurst, usrrst
    write_config(CMD_RESET_CTRL, 16'h0005);
    compare_value("usrrst", 1'b1, sys_ctrl.usrrst);
    compare_value("cpurst", 1'b0, sys_ctrl.cpurst);
    compare_value("cpuhlt", 1'b1, sys_ctrl.cpuhlt);
    write_config(CMD_RESET_CTRL, 16'h0002);
    compare_value("usrrst", 1'b0, sys_ctrl.usrrst);
    compare_value("cpurst", 1'b1, sys_ctrl.cpurst);
    compare_value("cpuhlt", 1'b0, sys_ctrl.cpuhlt);
    finish_test();

    begin_test("osd_video");
    for (i = 0; i < 256; i++) begin
      row_bytes[i] = osd_byte_t'($random(seed));
    end
    // words 0 to 2 are skipped, word 3 picks line 2 and highlights it
    start_cmd(CMD_OSD_BUFFER);
    for (i = 0; i < 3; i++) begin
      port_write(16'h0000, rb);
    end
    port_write(16'h0010 | HL_ROW, rb);
    for (i = 0; i < 256; i++) begin
      port_write({8'h00, row_bytes[i]}, rb);
    end
    end_cmd();
    frame_start();
    for (n = 1; n <= OSD_TOP + OSD_LINES + 1; n++) begin
      scan_line(n, 1'b1);
    end
    // osd off takes effect on the next frame
    write_config(CMD_OSD_CTRL, 16'h0000);
    frame_start();
    for (n = 1; n <= OSD_TOP + 10; n++) begin
      scan_line(n, 1'b0);
    end
    finish_test();

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, total_errs);
    if (tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
